// File: compile.f
logic/coleco_pkg.sv
logic/keypad_encoder.sv
logic/controller_ports.sv
logic/cart_loader.sv
logic/cart_storage_select.sv
logic/cpu_ram_port.sv
logic/coleco_glue_top.sv
verif/tb_coleco_glue.sv

// File: logic/cart_loader.sv
/*
 * Cartridge download tracker
 * Page count, SG-1000 detection and extra RAM detection from the load stream
 */
`timescale 1ns/1ps

module cart_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  coleco_pkg::load_beat_t load_i,
	output coleco_pkg::cart_mode_t mode_o
);
	import coleco_pkg::*;

	logic [PAGE_W-1:0] pages_q;
	logic              sg1000_q;
	logic              extram_q;
	logic              at_start;
	logic              in_xram_win;
	logic              win_first;

	// Address decodes for the current beat
	assign at_start    = (load_i.addr == '0);
	// 2000-3FFF
	assign in_xram_win = (load_i.addr[LOAD_ADDR_W-1:XRAM_WIN_LSB] == 1);
	assign win_first   = (load_i.addr[XRAM_WIN_LSB-1:0] == '0);

	// Last page written
	always_ff @(posedge clk_sys) begin
		if (load_i.wr) begin
			pages_q <= load_i.addr[PAGE_LSB +: PAGE_W];
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			sg1000_q <= 1'b0;
			extram_q <= 1'b0;
		end else if (load_i.wr) begin
			// New image starts
			if (at_start) begin
				extram_q <= 1'b0;
				sg1000_q <= (load_i.index[4:0] == SG1000_INDEX);
			end
			// Extra RAM marker, window must be all FF
			if (in_xram_win && sg1000_q) begin
				extram_q <= (win_first | extram_q) & (&load_i.data);
			end
		end
	end

	assign mode_o.pages  = pages_q;
	assign mode_o.sg1000 = sg1000_q;
	assign mode_o.extram = extram_q;

endmodule

// File: logic/cart_storage_select.sv
/*
 * Cartridge storage select
 * SDRAM or DDR3 choice, read routing and download pacing for DDR3 writes
 */
`timescale 1ns/1ps

module cart_storage_select (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  coleco_pkg::core_cfg_t  cfg_i,
	input  logic [15:0]            sdram_size_i,
	input  coleco_pkg::load_beat_t load_i,
	input  logic                   ddr_wr_ack_i,
	input  logic                   cart_rd_i,
	input  logic [7:0]             sdram_d_i,
	input  logic [7:0]             ddr_d_i,
	output logic                   load_wait_o,
	output logic                   sdram_rd_o,
	output logic                   ddr_rd_o,
	output logic [7:0]             cart_d_o
);
	import coleco_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_WAIT_ACK
	} wait_state_t;

	wait_state_t state_q;
	logic        use_sdr_d;
	logic        use_sdr_q;

	// Auto picks SDRAM when a module is fitted
	always_comb begin
		case (cfg_i.ram_type)
			RAMT_AUTO:  use_sdr_d = |sdram_size_i[2:0];
			RAMT_SDRAM: use_sdr_d = 1'b1;
			RAMT_DDR:   use_sdr_d = 1'b0;
			default:    use_sdr_d = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			use_sdr_q <= 1'b0;
		end else begin
			use_sdr_q <= use_sdr_d;
		end
	end

	// ==================================================
	// Download pacing, DDR3 only
	// ==================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state_q <= ST_IDLE;
		end else if (use_sdr_q) begin
			// SDRAM takes beats at full rate
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: if (load_i.wr) state_q <= ST_WAIT_ACK;
				ST_WAIT_ACK: if (ddr_wr_ack_i) state_q <= ST_IDLE;
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Hold the source until the write lands
	assign load_wait_o = (state_q == ST_WAIT_ACK);

	// Read strobe and data follow the selected store
	assign sdram_rd_o = cart_rd_i & use_sdr_q;
	assign ddr_rd_o   = cart_rd_i & ~use_sdr_q;
	assign cart_d_o   = use_sdr_q ? sdram_d_i : ddr_d_i;

endmodule

// File: logic/coleco_glue_top.sv
/*
 * ColecoVision host glue top level
 * Controller ports, cartridge loader, storage select and CPU RAM port
 */
`timescale 1ns/1ps

module coleco_glue_top (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  coleco_pkg::core_cfg_t                 cfg_i,
	input  logic [15:0]                           sdram_size_i,
	input  coleco_pkg::joy_t                      joy_a_i,
	input  coleco_pkg::joy_t                      joy_b_i,
	input  logic [1:0]                            sel_keys_n_i,
	input  logic [1:0]                            sel_dir_n_i,
	input  coleco_pkg::load_beat_t                load_i,
	input  logic                                  ddr_wr_ack_i,
	input  logic                                  cart_rd_i,
	input  logic [7:0]                            sdram_d_i,
	input  logic [7:0]                            ddr_d_i,
	input  logic [coleco_pkg::CPU_RAM_ADDR_W-1:0] cpu_ram_a_i,
	input  logic                                  ram_we_n_i,
	input  logic                                  ram_ce_n_i,
	output coleco_pkg::ctrl_port_t                ports_o [2],
	output coleco_pkg::cart_mode_t                mode_o,
	output logic                                  load_wait_o,
	output logic                                  sdram_rd_o,
	output logic                                  ddr_rd_o,
	output logic [7:0]                            cart_d_o,
	output logic [coleco_pkg::CPU_RAM_ADDR_W-1:0] ram_a_o,
	output logic                                  ram_we_o
);

	// ==================================================
	// Controller side, purely combinational
	// ==================================================
	controller_ports u_ports (
		.cfg_i        (cfg_i),
		.joy_a_i      (joy_a_i),
		.joy_b_i      (joy_b_i),
		.sel_keys_n_i (sel_keys_n_i),
		.sel_dir_n_i  (sel_dir_n_i),
		.ports_o      (ports_o)
	);

	// ==================================================
	// Cartridge download and storage
	// ==================================================
	cart_loader u_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.load_i  (load_i),
		.mode_o  (mode_o)
	);

	cart_storage_select u_store (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cfg_i        (cfg_i),
		.sdram_size_i (sdram_size_i),
		.load_i       (load_i),
		.ddr_wr_ack_i (ddr_wr_ack_i),
		.cart_rd_i    (cart_rd_i),
		.sdram_d_i    (sdram_d_i),
		.ddr_d_i      (ddr_d_i),
		.load_wait_o  (load_wait_o),
		.sdram_rd_o   (sdram_rd_o),
		.ddr_rd_o     (ddr_rd_o),
		.cart_d_o     (cart_d_o)
	);

	// CPU RAM, fold follows the detected cartridge mode
	cpu_ram_port u_ram (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_ram_a_i (cpu_ram_a_i),
		.ram_we_n_i  (ram_we_n_i),
		.ram_ce_n_i  (ram_ce_n_i),
		.mode_i      (mode_o),
		.ram_size_i  (cfg_i.ram_size),
		.ram_a_o     (ram_a_o),
		.ram_we_o    (ram_we_o)
	);

endmodule

// File: logic/coleco_pkg.sv
/*
 * ColecoVision host glue shared definitions
 * Widths, keypad codes, RAM option codes and the packed words between blocks
 */
package coleco_pkg;

	// ==================================================
	// Widths and address fields
	// ==================================================
	localparam int LOAD_ADDR_W    = 25;
	localparam int CPU_RAM_ADDR_W = 15;
	localparam int PAGE_W         = 6;
	// Page count sits at download address bits 19..14
	localparam int PAGE_LSB       = 14;
	// 8 KB window, 2000-3FFF is window number 1
	localparam int XRAM_WIN_LSB   = 13;
	localparam int RAM_8K_AW      = 13;
	localparam int RAM_1K_AW      = 10;
	// Divide by 4 for the RAM clock enable
	localparam int CE_DIV_W       = 2;

	// RAM size and storage type option codes
	localparam logic [1:0] RAM_1K     = 2'd0;
	localparam logic [1:0] RAM_8K     = 2'd1;
	localparam logic [1:0] RAM_SGM    = 2'd2;
	localparam logic [1:0] RAMT_AUTO  = 2'd0;
	localparam logic [1:0] RAMT_SDRAM = 2'd1;
	localparam logic [1:0] RAMT_DDR   = 2'd2;

	// Download slot of an SG-1000 image, low 5 index bits
	localparam logic [4:0] SG1000_INDEX = 5'd2;

	// ==================================================
	// Keypad codes, active low as seen on p1..p4
	// ==================================================
	localparam logic [3:0] KEY_0        = 4'b0011;
	localparam logic [3:0] KEY_1        = 4'b1110;
	localparam logic [3:0] KEY_2        = 4'b1101;
	localparam logic [3:0] KEY_3        = 4'b0110;
	localparam logic [3:0] KEY_4        = 4'b0001;
	localparam logic [3:0] KEY_5        = 4'b1001;
	localparam logic [3:0] KEY_6        = 4'b0111;
	localparam logic [3:0] KEY_7        = 4'b1100;
	localparam logic [3:0] KEY_8        = 4'b1000;
	localparam logic [3:0] KEY_9        = 4'b1011;
	localparam logic [3:0] KEY_ASTERISK = 4'b1010;
	localparam logic [3:0] KEY_NUMBER   = 4'b0101;
	localparam logic [3:0] KEY_PURPLE   = 4'b0100;
	localparam logic [3:0] KEY_BLUE     = 4'b0010;
	localparam logic [3:0] KEY_NONE     = 4'b1111;

	// Joystick word from the host, all active high
	typedef struct packed {
		logic [11:0] spare;
		logic        blue_tr;
		logic        purple_tr;
		// Digit n at bit 8+n
		logic [9:0]  digit;
		logic        number;
		logic        asterisk;
		logic        fire2;
		logic        fire1;
		logic        up;
		logic        down;
		logic        left;
		logic        right;
	} joy_t;

	// Controller port pins, active low, idle all ones
	typedef struct packed {
		logic [3:0] nibble;
		logic       p6;
	} ctrl_port_t;

	typedef struct packed {
		logic [1:0] ram_size;
		logic [1:0] ram_type;
		logic       joy_swap;
	} core_cfg_t;

	// One download beat
	typedef struct packed {
		logic                   wr;
		logic [7:0]             index;
		logic [LOAD_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} load_beat_t;

	typedef struct packed {
		logic [PAGE_W-1:0] pages;
		logic              sg1000;
		logic              extram;
	} cart_mode_t;

endpackage

// File: logic/controller_ports.sv
/*
 * Controller ports
 * Optional player swap ahead of one keypad encoder per port
 */
`timescale 1ns/1ps

module controller_ports (
	input  coleco_pkg::core_cfg_t  cfg_i,
	input  coleco_pkg::joy_t       joy_a_i,
	input  coleco_pkg::joy_t       joy_b_i,
	input  logic [1:0]             sel_keys_n_i,
	input  logic [1:0]             sel_dir_n_i,
	output coleco_pkg::ctrl_port_t ports_o [2]
);
	import coleco_pkg::*;

	// Joystick feeding each port after the swap
	joy_t joy_sel [2];

	assign joy_sel[0] = cfg_i.joy_swap ? joy_b_i : joy_a_i;
	assign joy_sel[1] = cfg_i.joy_swap ? joy_a_i : joy_b_i;

	// One encoder per port
	for (genvar i = 0; i < 2; i++) begin : g_port
		keypad_encoder u_enc (
			.joy_i        (joy_sel[i]),
			.sel_keys_n_i (sel_keys_n_i[i]),
			.sel_dir_n_i  (sel_dir_n_i[i]),
			.port_o       (ports_o[i])
		);
	end

endmodule

// File: logic/cpu_ram_port.sv
/*
 * CPU RAM port
 * Quarter-rate write enable and address fold to the configured RAM size
 */
`timescale 1ns/1ps

module cpu_ram_port (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic [coleco_pkg::CPU_RAM_ADDR_W-1:0] cpu_ram_a_i,
	input  logic                                  ram_we_n_i,
	input  logic                                  ram_ce_n_i,
	input  coleco_pkg::cart_mode_t                mode_i,
	input  logic [1:0]                            ram_size_i,
	output logic [coleco_pkg::CPU_RAM_ADDR_W-1:0] ram_a_o,
	output logic                                  ram_we_o
);
	import coleco_pkg::*;

	logic [CE_DIV_W-1:0] div_q;
	logic                ce_q;

	// Free-running divider, enable on wrap
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_q <= '0;
			ce_q  <= 1'b0;
		end else begin
			div_q <= div_q + 1'b1;
			ce_q  <= (div_q == '1);
		end
	end

	// Fold, unused upper bits forced to zero
	always_comb begin
		ram_a_o = '0;
		if (mode_i.extram) begin
			ram_a_o = cpu_ram_a_i;
		end else if (ram_size_i == RAM_8K) begin
			ram_a_o[RAM_8K_AW-1:0] = cpu_ram_a_i[RAM_8K_AW-1:0];
		end else if (ram_size_i == RAM_1K) begin
			ram_a_o[RAM_1K_AW-1:0] = cpu_ram_a_i[RAM_1K_AW-1:0];
		end else if (mode_i.sg1000) begin
			// SGM on SG-1000 still means 8 KB
			ram_a_o[RAM_8K_AW-1:0] = cpu_ram_a_i[RAM_8K_AW-1:0];
		end else begin
			ram_a_o = cpu_ram_a_i;
		end
	end

	// Write only on an enable cycle with both strobes active
	assign ram_we_o = ce_q & ~ram_we_n_i & ~ram_ce_n_i;

endmodule

// File: logic/keypad_encoder.sv
/*
 * Keypad encoder for one controller port
 * Keypad half and direction half, each enabled by its own strobe
 */
`timescale 1ns/1ps

module keypad_encoder (
	input  coleco_pkg::joy_t       joy_i,
	input  logic                   sel_keys_n_i,
	input  logic                   sel_dir_n_i,
	output coleco_pkg::ctrl_port_t port_o
);
	import coleco_pkg::*;

	// Keys in priority order, bit 0 wins
	logic [13:0]  keys;
	logic [3:0]   key_code;
	ctrl_port_t   keys_half;
	ctrl_port_t   dir_half;

	assign keys = {joy_i.blue_tr, joy_i.purple_tr, joy_i.number, joy_i.asterisk, joy_i.digit};

	// Digits first, then asterisk, number, purple, blue
	always_comb begin
		casez (keys)
			14'b?????????????1: key_code = KEY_0;
			14'b????????????10: key_code = KEY_1;
			14'b???????????100: key_code = KEY_2;
			14'b??????????1000: key_code = KEY_3;
			14'b?????????10000: key_code = KEY_4;
			14'b????????100000: key_code = KEY_5;
			14'b???????1000000: key_code = KEY_6;
			14'b??????10000000: key_code = KEY_7;
			14'b?????100000000: key_code = KEY_8;
			14'b????1000000000: key_code = KEY_9;
			14'b???10000000000: key_code = KEY_ASTERISK;
			14'b??100000000000: key_code = KEY_NUMBER;
			14'b?1000000000000: key_code = KEY_PURPLE;
			14'b10000000000000: key_code = KEY_BLUE;
			default:            key_code = KEY_NONE;
		endcase
	end

	// Keypad half, fire2 on p6
	assign keys_half.nibble = sel_keys_n_i ? 4'b1111 : key_code;
	assign keys_half.p6     = sel_keys_n_i | ~joy_i.fire2;

	// Direction half, fire1 on p6
	assign dir_half.nibble = sel_dir_n_i ? 4'b1111 :
		~{joy_i.up, joy_i.down, joy_i.left, joy_i.right};
	assign dir_half.p6     = sel_dir_n_i | ~joy_i.fire1;

	// Open-collector style merge of both halves
	assign port_o = keys_half & dir_half;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_coleco_glue -o sim_tb

./obj_dir/sim_tb | tee sim.log

# Pass only when the testbench reported it
grep -q "TEST RESULT: PASS" sim.log

// File: verif/tb_coleco_glue.sv
/*
 * Testbench for the ColecoVision host glue
 * Stands in for the console core and both storage controllers
 */
`timescale 1ns/1ps

module tb_coleco_glue;
	import coleco_pkg::*;

	localparam int CLK_PERIOD = 4;
	// Test lengths in cycles
	localparam int LEN_KEYS   = 40;
	localparam int LEN_DIR    = 80;
	localparam int LEN_LOAD   = 8300;
	localparam int LEN_FOLD   = 120;
	localparam int LEN_GATE   = 60;
	localparam int LEN_STORE  = 80;
	// Sum plus a margin for reset and the gaps between tests
	localparam int LEN_ALL    = LEN_KEYS + LEN_DIR + LEN_LOAD + LEN_FOLD + LEN_GATE +
		LEN_STORE + 200;

	logic                      clk_sys = 1'b0;
	logic                      reset;
	core_cfg_t                 cfg;
	logic [15:0]               sdram_size;
	joy_t                      joy_a;
	joy_t                      joy_b;
	logic [1:0]                sel_keys_n;
	logic [1:0]                sel_dir_n;
	load_beat_t                load;
	logic                      ddr_wr_ack;
	logic                      cart_rd;
	logic [7:0]                sdram_d;
	logic [7:0]                ddr_d;
	logic [CPU_RAM_ADDR_W-1:0] cpu_ram_a;
	logic                      ram_we_n;
	logic                      ram_ce_n;
	ctrl_port_t                ports [2];
	cart_mode_t                mode;
	logic                      load_wait;
	logic                      sdram_rd;
	logic                      ddr_rd;
	logic [7:0]                cart_d;
	logic [CPU_RAM_ADDR_W-1:0] ram_a;
	logic                      ram_we;

	logic [31:0] lfsr = 32'he100_3bad;
	int          err_count = 0;
	int          test_count = 0;
	int          test_fails = 0;
	int          err_at_start = 0;

	coleco_glue_top dut_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cfg_i        (cfg),
		.sdram_size_i (sdram_size),
		.joy_a_i      (joy_a),
		.joy_b_i      (joy_b),
		.sel_keys_n_i (sel_keys_n),
		.sel_dir_n_i  (sel_dir_n),
		.load_i       (load),
		.ddr_wr_ack_i (ddr_wr_ack),
		.cart_rd_i    (cart_rd),
		.sdram_d_i    (sdram_d),
		.ddr_d_i      (ddr_d),
		.cpu_ram_a_i  (cpu_ram_a),
		.ram_we_n_i   (ram_we_n),
		.ram_ce_n_i   (ram_ce_n),
		.ports_o      (ports),
		.mode_o       (mode),
		.load_wait_o  (load_wait),
		.sdram_rd_o   (sdram_rd),
		.ddr_rd_o     (ddr_rd),
		.cart_d_o     (cart_d),
		.ram_a_o      (ram_a),
		.ram_we_o     (ram_we)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ==================================================
	// Protocol properties
	// ==================================================
	// Wait flag drops on the edge after an acknowledge
	wait_release: assert property (@(posedge clk_sys) disable iff (reset)
		(load_wait && ddr_wr_ack) |=> !load_wait)
		else begin
			$display("Download wait flag stayed high after the DDR3 acknowledge");
			err_count++;
		end

	// Never both stores at once
	one_reader: assert property (@(posedge clk_sys) disable iff (reset)
		!(sdram_rd && ddr_rd))
		else begin
			$display("Cartridge read strobe reached SDRAM and DDR3 together");
			err_count++;
		end

	// ==================================================
	// Helpers
	// ==================================================
	// Galois LFSR on x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	// Key k pressed with nothing of higher priority
	// k of 14 leaves every key released
	task automatic rand_joy(input int k, output joy_t j);
		logic [31:0] r;
		logic [13:0] keys;
		rand_bits(32, r);
		j = r;
		rand_bits(14, r);
		keys = r[13:0];
		if (k < 14) begin
			keys = (keys & ~((14'd1 << k) - 14'd1)) | (14'd1 << k);
		end else begin
			keys = '0;
		end
		{j.blue_tr, j.purple_tr, j.number, j.asterisk, j.digit} = keys;
	endtask

	// Priority runs digits 0..9 then asterisk, number, purple and blue
	function automatic logic [3:0] key_expect(input joy_t j);
		logic [13:0] pressed;
		logic [3:0]  codes [14];
		logic [3:0]  code;
		codes   = '{KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
			KEY_ASTERISK, KEY_NUMBER, KEY_PURPLE, KEY_BLUE};
		pressed = {j.blue_tr, j.purple_tr, j.number, j.asterisk, j.digit};
		code    = KEY_NONE;
		for (int i = 13; i >= 0; i--) begin
			if (pressed[i]) code = codes[i];
		end
		return code;
	endfunction

	// Unselected half idles high and the halves AND together
	function automatic ctrl_port_t port_expect(input joy_t j, input logic keys_n,
		input logic dir_n);
		ctrl_port_t kh;
		ctrl_port_t dh;
		kh = keys_n ? 5'h1f : {key_expect(j), ~j.fire2};
		dh = dir_n ? 5'h1f : {~j.up, ~j.down, ~j.left, ~j.right, ~j.fire1};
		return kh & dh;
	endfunction

	function automatic logic [CPU_RAM_ADDR_W-1:0] fold_expect(
		input logic [CPU_RAM_ADDR_W-1:0] a, input logic [1:0] size, input logic sg,
		input logic ext);
		if (ext) return a;
		else if (size == RAM_8K) return a & 15'h1fff;
		else if (size == RAM_1K) return a & 15'h03ff;
		else if (sg) return a & 15'h1fff;
		return a;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("ERR %s expected %0h actual %0h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_ports(input string name);
		joy_t src0;
		joy_t src1;
		src0 = cfg.joy_swap ? joy_b : joy_a;
		src1 = cfg.joy_swap ? joy_a : joy_b;
		check_val({name, " port0"}, 32'(port_expect(src0, sel_keys_n[0], sel_dir_n[0])),
			32'(ports[0]));
		check_val({name, " port1"}, 32'(port_expect(src1, sel_keys_n[1], sel_dir_n[1])),
			32'(ports[1]));
	endtask

	// Inputs change 1 ns after the edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) tick();
		reset = 1'b0;
	endtask

	task automatic send_beat(input logic [7:0] idx, input logic [LOAD_ADDR_W-1:0] a,
		input logic [7:0] d);
		load.wr    = 1'b1;
		load.index = idx;
		load.addr  = a;
		load.data  = d;
		tick();
		load.wr = 1'b0;
	endtask

	task automatic start_test();
		err_at_start = err_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == err_at_start) begin
			$display("test %s ok", name);
		end else begin
			test_fails++;
			$display("test %s failed with %0d errors", name, err_count - err_at_start);
		end
	endtask

	// Strobe and data land on the chosen store only
	task automatic check_route(input string name, input logic sdr);
		cart_rd = 1'b1;
		sdram_d = 8'h5a;
		ddr_d   = 8'ha5;
		#1;
		check_val({name, " sdram_rd"}, 32'(sdr), 32'(sdram_rd));
		check_val({name, " ddr_rd"}, 32'(!sdr), 32'(ddr_rd));
		check_val({name, " cart_d"}, sdr ? 32'h5a : 32'ha5, 32'(cart_d));
		tick();
		cart_rd = 1'b0;
		#1;
		check_val({name, " idle strobes"}, 32'd0, 32'({sdram_rd, ddr_rd}));
		tick();
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic test_keypad();
		start_test();
		cfg.joy_swap = 1'b0;
		for (int k = 0; k <= 14; k++) begin
			rand_joy(k, joy_a);
			rand_joy(14 - k, joy_b);
			sel_keys_n = 2'b00;
			sel_dir_n  = 2'b11;
			#1;
			check_ports("keypad");
			sel_keys_n = 2'b11;
			#1;
			check_ports("keypad idle");
			tick();
		end
		end_test("keypad");
	endtask

	task automatic test_direction();
		start_test();
		for (int s = 0; s < 2; s++) begin
			cfg.joy_swap = s[0];
			for (int n = 0; n < 16; n++) begin
				rand_joy(n % 15, joy_a);
				rand_joy((n + 7) % 15, joy_b);
				sel_keys_n = 2'b11;
				sel_dir_n  = 2'b00;
				#1;
				check_ports("direction");
				sel_keys_n = 2'b00;
				#1;
				check_ports("merge");
				tick();
			end
		end
		sel_keys_n = 2'b11;
		sel_dir_n  = 2'b11;
		end_test("direction");
	endtask

	task automatic test_load();
		logic [LOAD_ADDR_W-1:0] last_a;
		start_test();
		// Nothing loaded since reset
		check_val("load reset sg1000", 32'd0, 32'(mode.sg1000));
		check_val("load reset extram", 32'd0, 32'(mode.extram));
		check_val("load reset wait", 32'd0, 32'(load_wait));
		send_beat(8'd2, '0, 8'h00);
		check_val("load sg1000 set", 32'd1, 32'(mode.sg1000));
		check_val("load extram clear", 32'd0, 32'(mode.extram));
		// Whole 2000-3FFF window filled with FF
		for (int a = 'h2000; a < 'h4000; a++) begin
			send_beat(8'd2, LOAD_ADDR_W'(a), 8'hff);
		end
		check_val("load extram set", 32'd1, 32'(mode.extram));
		send_beat(8'd2, 25'h0002100, 8'h12);
		check_val("load extram dropped", 32'd0, 32'(mode.extram));
		last_a = 25'h00ac000;
		send_beat(8'd2, last_a, 8'h00);
		check_val("load pages", 32'(last_a[19:14]), 32'(mode.pages));
		// Plain ColecoVision image ignores the window
		send_beat(8'd1, '0, 8'h00);
		check_val("load sg1000 clear", 32'd0, 32'(mode.sg1000));
		send_beat(8'd1, 25'h0002000, 8'hff);
		check_val("load extram needs sg1000", 32'd0, 32'(mode.extram));
		end_test("load");
	endtask

	task automatic test_fold();
		logic [31:0] r;
		logic        sg;
		logic        ext;
		start_test();
		for (int m = 0; m < 3; m++) begin
			sg  = (m != 0);
			ext = (m == 2);
			send_beat(sg ? 8'd2 : 8'd1, '0, 8'h00);
			// First window byte alone starts the FF check
			if (ext) send_beat(8'd2, 25'h0002000, 8'hff);
			for (int size = 0; size < 4; size++) begin
				cfg.ram_size = 2'(size);
				for (int n = 0; n < 4; n++) begin
					rand_bits(15, r);
					cpu_ram_a = r[14:0];
					#1;
					check_val($sformatf("fold size %0d sg %0d ext %0d", size, sg, ext),
						32'(fold_expect(r[14:0], 2'(size), sg, ext)), 32'(ram_a));
					tick();
				end
			end
		end
		cfg.ram_size = RAM_8K;
		end_test("fold");
	endtask

	task automatic test_write_gate();
		int pulses;
		start_test();
		pulses   = 0;
		ram_we_n = 1'b0;
		ram_ce_n = 1'b0;
		apply_reset();
		// Enable every 4th cycle starting 4 cycles after release
		for (int n = 1; n <= 40; n++) begin
			tick();
			check_val($sformatf("write gate cycle %0d", n), (n % 4 == 0) ? 32'd1 : 32'd0,
				32'(ram_we));
			if (ram_we) pulses++;
		end
		check_val("write gate pulses", 32'd10, 32'(pulses));
		// Each span covers one enable cycle with a single request active
		ram_we_n = 1'b1;
		for (int n = 1; n <= 4; n++) begin
			tick();
			check_val("write gate we_n high", 32'd0, 32'(ram_we));
		end
		ram_we_n = 1'b0;
		ram_ce_n = 1'b1;
		for (int n = 1; n <= 4; n++) begin
			tick();
			check_val("write gate ce_n high", 32'd0, 32'(ram_we));
		end
		ram_we_n = 1'b1;
		ram_ce_n = 1'b1;
		end_test("write gate");
	endtask

	task automatic test_storage();
		start_test();
		cfg.ram_type = RAMT_DDR;
		sdram_size   = 16'h0000;
		tick();
		check_route("ddr", 1'b0);
		send_beat(8'd2, 25'h0000100, 8'h3c);
		check_val("ddr wait rise", 32'd1, 32'(load_wait));
		repeat (3) begin
			tick();
			check_val("ddr wait hold", 32'd1, 32'(load_wait));
		end
		ddr_wr_ack = 1'b1;
		tick();
		ddr_wr_ack = 1'b0;
		check_val("ddr wait fall", 32'd0, 32'(load_wait));
		// SDRAM takes beats without a wait
		cfg.ram_type = RAMT_SDRAM;
		tick();
		check_route("sdram", 1'b1);
		send_beat(8'd2, 25'h0000101, 8'h3d);
		repeat (4) begin
			check_val("sdram no wait", 32'd0, 32'(load_wait));
			tick();
		end
		// In auto mode only size bits 2..0 count
		cfg.ram_type = RAMT_AUTO;
		sdram_size   = 16'h0004;
		tick();
		check_route("auto fitted", 1'b1);
		sdram_size = 16'hfff8;
		tick();
		check_route("auto absent", 1'b0);
		end_test("storage");
	endtask

	// ==================================================
	// Run
	// ==================================================
	initial begin
		reset      = 1'b1;
		cfg        = '{ram_size: RAM_8K, ram_type: RAMT_SDRAM, joy_swap: 1'b0};
		sdram_size = 16'h0001;
		joy_a      = '0;
		joy_b      = '0;
		sel_keys_n = 2'b11;
		sel_dir_n  = 2'b11;
		load       = '0;
		ddr_wr_ack = 1'b0;
		cart_rd    = 1'b0;
		sdram_d    = 8'h00;
		ddr_d      = 8'h00;
		cpu_ram_a  = '0;
		ram_we_n   = 1'b1;
		ram_ce_n   = 1'b1;
		apply_reset();
		test_keypad();
		test_direction();
		test_load();
		test_fold();
		test_write_gate();
		test_storage();
		$display("tests run %0d, tests failed %0d, errors %0d", test_count, test_fails,
			err_count);
		if (err_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog over the summed test lengths
	initial begin
		#(LEN_ALL * CLK_PERIOD);
		$display("Watchdog timeout, tests did not finish within %0d cycles", LEN_ALL);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
